// File: Makefile
SIM := obj_dir/Vchip_mmc1_tb

all: run

$(SIM): chip_mmc1.f $(wildcard source/*.sv) $(wildcard dv/*.sv)
	verilator --binary --assert -j 0 --top-module chip_mmc1_tb -f chip_mmc1.f \
		-Mdir obj_dir -o Vchip_mmc1_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: chip_mmc1.f
source/mmc1_pkg.sv
source/mmc1_serial_loader.sv
source/mmc1_bank_regs.sv
source/mmc1_addr_map.sv
source/mmc1_state_apb.sv
source/chip_mmc1.sv
dv/chip_mmc1_tb.sv

// File: dv/chip_mmc1_tb.sv
`timescale 1ns/1ps
`default_nettype none

module chip_mmc1_tb;

	typedef enum logic [2:0] {OP_LOAD, OP_D7, OP_DOUBLE, OP_APBW, OP_APBR} op_t;

	typedef struct packed {
		op_t op;
		logic [7:0] arg; // Target or APB address.
		logic [7:0] val; // Load bits, write data or read expectation.
		logic [2:0] nbits;
	} entry_t;

	logic cpu_m2;
	logic rst;
	logic [14:13] cpu_addr;
	logic cpu_d7;
	logic cpu_d0;
	logic cpu_ce_n;
	logic cpu_rw;
	logic [12:10] ppu_addr;
	logic wram_ce;
	logic prg_ce_n;
	logic ciram_a10;
	mmc1_pkg::prg_bank_t prg_addr;
	mmc1_pkg::chr_bank_t chr_addr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [7:0] pwdata;
	logic [7:0] prdata;
	logic pready;
	logic pslverr;

	// Reference model state.
	mmc1_pkg::reg_word_t m_ctrl;
	mmc1_pkg::reg_word_t m_chr0;
	mmc1_pkg::reg_word_t m_chr1;
	mmc1_pkg::reg_word_t m_prg;
	mmc1_pkg::reg_word_t m_shift;
	logic [2:0] m_count;

	entry_t tab[$];
	string names[$];
	logic tab_ready;
	logic [6:0] sweep_pts [4]; // {ce_n, rw, cpu_addr, ppu_addr}.

	chip_mmc1 dut (.*);

	initial
	begin
		cpu_m2 = 1'b0;
		forever #5 cpu_m2 = ~cpu_m2;
	end

	initial
	begin
		wait (tab_ready);
		#((tab.size() + 2) * 20 * 10);
		$display("Timeout: the test table did not finish in time");
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

	task automatic report_mismatch(input string name, input logic [7:0] expv,
			input logic [7:0] act);
		$display("[FAIL] %s: expected %0h, actual %0h", name, expv, act);
		$display("Test failures found");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_prg(input string name, input mmc1_pkg::prg_bank_t expv,
			input mmc1_pkg::prg_bank_t act);
		if (act !== expv)
			report_mismatch(name, {4'h0, expv}, {4'h0, act});
	endtask

	task automatic check_chr(input string name, input mmc1_pkg::chr_bank_t expv,
			input mmc1_pkg::chr_bank_t act);
		if (act !== expv)
			report_mismatch(name, {3'b000, expv}, {3'b000, act});
	endtask

	task automatic check_bit(input string name, input logic expv, input logic act);
		if (act !== expv)
			report_mismatch(name, {7'h00, expv}, {7'h00, act});
	endtask

	task automatic check_byte(input string name, input logic [7:0] expv,
			input logic [7:0] act);
		if (act !== expv)
			report_mismatch(name, expv, act);
	endtask

	function automatic void add_entry(input op_t op, input logic [7:0] arg,
			input logic [7:0] val, input logic [2:0] nbits, input string name);
		entry_t e;
		e.op = op;
		e.arg = arg;
		e.val = val;
		e.nbits = nbits;
		tab.push_back(e);
		names.push_back(name);
	endfunction

	function automatic mmc1_pkg::reg_word_t rand_word();
		logic [31:0] r;
		r = $urandom;
		return r[4:0];
	endfunction

	function automatic void commit_word(input logic [2:0] sel, input mmc1_pkg::reg_word_t w);
		case (sel)
			3'd0: m_ctrl = w;
			3'd1: m_chr0 = w;
			3'd2: m_chr1 = w;
			3'd3: m_prg = w;
			3'd4: m_shift = w;
			default: m_count = w[2:0];
		endcase
	endfunction

	// LSB first, fifth bit commits.
	function automatic void model_bit(input logic [1:0] sel, input logic d0);
		m_shift = {d0, m_shift[4:1]};
		if (m_count == mmc1_pkg::COMMIT_COUNT)
		begin
			commit_word({1'b0, sel}, m_shift);
			m_count = 3'd0;
		end
		else
			m_count = m_count + 3'd1;
	endfunction

	// Control is {chr_mode, prg_mode[1:0], mirror[1:0]}.
	function automatic mmc1_pkg::prg_bank_t exp_prg(input logic a14);
		case (m_ctrl[3:2])
			2'd2: return a14 ? m_prg[3:0] : 4'h0;
			2'd3: return a14 ? 4'hf : m_prg[3:0];
			default: return {m_prg[3:1], a14};
		endcase
	endfunction

	function automatic mmc1_pkg::chr_bank_t exp_chr(input logic p12);
		if (!m_ctrl[4])
			return {m_chr0[4:1], p12};
		else
			return p12 ? m_chr1 : m_chr0;
	endfunction

	function automatic logic exp_ciram(input logic p11, input logic p10);
		case (m_ctrl[1:0])
			2'd0: return 1'b0;
			2'd1: return 1'b1;
			2'd2: return p10;
			default: return p11;
		endcase
	endfunction

	task automatic cpu_write(input logic [1:0] sel, input logic d7, input logic d0,
			input logic twice);
		@(negedge cpu_m2);
		cpu_addr = sel;
		cpu_ce_n = 1'b0;
		cpu_rw = 1'b0;
		cpu_d7 = d7;
		cpu_d0 = d0;
		if (twice)
		begin
			@(negedge cpu_m2);
			cpu_d0 = !d0; // Dummy write of an RMW pair.
		end
		@(negedge cpu_m2);
		cpu_ce_n = 1'b1;
		cpu_rw = 1'b1;
		cpu_d7 = 1'b0;
	endtask

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [7:0] wdata,
			output logic [7:0] rdata, output logic err, output logic ready);
		@(negedge cpu_m2);
		psel = 1'b1;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge cpu_m2);
		penable = 1'b1;
		#2;
		ready = pready; // Zero wait states.
		rdata = prdata;
		err = pslverr;
		@(negedge cpu_m2);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	// No write cycles here, so the loader is left alone.
	task automatic check_outputs(input string name);
		logic [6:0] pt;
		for (int i = 0; i < 4; i++)
		begin
			@(negedge cpu_m2);
			pt = sweep_pts[i];
			{cpu_ce_n, cpu_rw, cpu_addr, ppu_addr} = pt;
			#2;
			check_prg({name, " prg_addr"}, exp_prg(pt[4]), prg_addr);
			check_chr({name, " chr_addr"}, exp_chr(pt[2]), chr_addr);
			check_bit({name, " ciram_a10"}, exp_ciram(pt[1], pt[0]), ciram_a10);
			check_bit({name, " wram_ce"}, pt[6] && (pt[4:3] == 2'b11) && !m_prg[4], wram_ce);
			check_bit({name, " prg_ce_n"}, !(!pt[6] && pt[5]), prg_ce_n);
		end
	endtask

	task automatic apply_entry(input entry_t e, input string name);
		logic [7:0] bits;
		logic [7:0] rdata;
		logic err;
		logic ready;
		case (e.op)
			OP_LOAD:
			begin
				bits = e.val;
				for (int k = 0; k < int'(e.nbits); k++)
				begin
					cpu_write(e.arg[1:0], 1'b0, bits[0], 1'b0);
					model_bit(e.arg[1:0], bits[0]);
					bits = bits >> 1;
				end
			end
			OP_D7:
			begin
				cpu_write(e.arg[1:0], 1'b1, 1'b0, 1'b0);
				m_count = 3'd0;
				m_ctrl[3:2] = 2'b11; // Last bank fixed.
			end
			OP_DOUBLE:
			begin
				cpu_write(e.arg[1:0], 1'b0, e.val[0], 1'b1);
				model_bit(e.arg[1:0], e.val[0]);
			end
			default:
			begin
				apb_access(e.op == OP_APBW, e.arg, e.val, rdata, err, ready);
				check_bit({name, " pready"}, 1'b1, ready);
				check_bit({name, " pslverr"}, e.arg > mmc1_pkg::SST_LAST, err);
				if (e.op == OP_APBR)
					check_byte({name, " prdata"}, e.val, rdata);
				else if (e.arg <= mmc1_pkg::SST_LAST)
					commit_word(e.arg[2:0], e.val[4:0]);
			end
		endcase
	endtask

	initial
	begin
		mmc1_pkg::reg_word_t rp;
		mmc1_pkg::reg_word_t rp2;
		mmc1_pkg::reg_word_t rc0;
		mmc1_pkg::reg_word_t rc1;
		mmc1_pkg::reg_word_t rc2;
		mmc1_pkg::reg_word_t rc3;
		tab_ready = 1'b0;
		rst = 1'b1;
		cpu_addr = 2'b00;
		cpu_d7 = 1'b0;
		cpu_d0 = 1'b0;
		cpu_ce_n = 1'b1;
		cpu_rw = 1'b1;
		ppu_addr = 3'b000;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 8'h00;
		sweep_pts = '{7'b0100001, 7'b1011010, 7'b1100110, 7'b1111101};
		void'($urandom(73));
		rp = rand_word() & 5'h0f;
		rp2 = rand_word() | 5'h10;
		rc0 = rand_word();
		rc1 = rand_word();
		rc2 = rand_word();
		rc3 = rand_word();

		add_entry(OP_APBR, 8'd0, 8'h1f, 3'd0, "reset ctrl");
		add_entry(OP_APBR, 8'd1, 8'h00, 3'd0, "reset chr0");
		add_entry(OP_APBR, 8'd2, 8'h00, 3'd0, "reset chr1");
		add_entry(OP_APBR, 8'd3, 8'h00, 3'd0, "reset prg");
		add_entry(OP_APBR, 8'd4, 8'h00, 3'd0, "reset shift");
		add_entry(OP_APBR, 8'd5, 8'h00, 3'd0, "reset count");
		add_entry(OP_LOAD, 8'd3, {3'b000, rp}, 3'd5, "load prg");
		add_entry(OP_APBR, 8'd3, {3'b000, rp}, 3'd0, "read prg");
		add_entry(OP_LOAD, 8'd0, 8'h08, 3'd5, "prg mode 2 one screen low");
		add_entry(OP_LOAD, 8'd1, {3'b000, rc0}, 3'd5, "load chr0");
		add_entry(OP_LOAD, 8'd2, {3'b000, rc1}, 3'd5, "load chr1");
		add_entry(OP_LOAD, 8'd0, 8'h11, 3'd5, "prg mode 0 chr 4k one screen high");
		add_entry(OP_LOAD, 8'd0, 8'h16, 3'd5, "prg mode 1 chr 4k vertical");
		add_entry(OP_LOAD, 8'd0, 8'h0f, 3'd5, "prg mode 3 chr 8k horizontal");
		add_entry(OP_APBR, 8'd1, {3'b000, rc0}, 3'd0, "read chr0");
		add_entry(OP_APBR, 8'd2, {3'b000, rc1}, 3'd0, "read chr1");
		add_entry(OP_LOAD, 8'd0, 8'h12, 3'd5, "prg mode 0 before d7");
		add_entry(OP_LOAD, 8'd2, 8'h03, 3'd2, "two bits before d7");
		add_entry(OP_APBR, 8'd5, 8'h02, 3'd0, "count before d7");
		add_entry(OP_D7, 8'd2, 8'h00, 3'd0, "d7 reset");
		add_entry(OP_APBR, 8'd5, 8'h00, 3'd0, "count after d7");
		add_entry(OP_APBR, 8'd0, 8'h1e, 3'd0, "prg mode after d7");
		add_entry(OP_LOAD, 8'd2, {3'b000, rc2}, 3'd5, "load after d7");
		add_entry(OP_APBR, 8'd2, {3'b000, rc2}, 3'd0, "read chr1 after d7");
		add_entry(OP_DOUBLE, 8'd1, 8'h01, 3'd0, "rmw double write");
		add_entry(OP_APBR, 8'd5, 8'h01, 3'd0, "count after double write");
		add_entry(OP_APBR, 8'd4, {3'b000, 1'b1, rc2[4:1]}, 3'd0, "shift after double write");
		add_entry(OP_APBW, 8'd0, 8'h09, 3'd0, "write ctrl");
		add_entry(OP_APBR, 8'd0, 8'h09, 3'd0, "read ctrl");
		add_entry(OP_APBW, 8'd1, {3'b000, rc3}, 3'd0, "write chr0");
		add_entry(OP_APBR, 8'd1, {3'b000, rc3}, 3'd0, "read written chr0");
		add_entry(OP_APBW, 8'd2, 8'he7, 3'd0, "write chr1 wide data");
		add_entry(OP_APBR, 8'd2, 8'h07, 3'd0, "read chr1 low bits");
		add_entry(OP_APBW, 8'd3, {3'b000, rp2}, 3'd0, "write prg wram off");
		add_entry(OP_APBR, 8'd3, {3'b000, rp2}, 3'd0, "read written prg");
		add_entry(OP_APBW, 8'd4, 8'h15, 3'd0, "write shift");
		add_entry(OP_APBR, 8'd4, 8'h15, 3'd0, "read shift");
		add_entry(OP_APBW, 8'd5, 8'h04, 3'd0, "write count");
		add_entry(OP_APBR, 8'd5, 8'h04, 3'd0, "read count");
		add_entry(OP_LOAD, 8'd0, 8'h01, 3'd1, "commit from restored count");
		add_entry(OP_APBR, 8'd0, 8'h1a, 3'd0, "ctrl from restored count");
		add_entry(OP_APBW, 8'd6, 8'h00, 3'd0, "write bad address");
		add_entry(OP_APBR, 8'd6, 8'hff, 3'd0, "read bad address");
		add_entry(OP_APBR, 8'hff, 8'hff, 3'd0, "read top address");
		tab_ready = 1'b1;

		m_ctrl = 5'h1f;
		m_chr0 = 5'h00;
		m_chr1 = 5'h00;
		m_prg = 5'h00;
		m_shift = 5'h00;
		m_count = 3'd0;
		repeat (4) @(posedge cpu_m2);
		@(negedge cpu_m2);
		rst = 1'b0;

		check_outputs("after reset");
		foreach (tab[i])
		begin
			apply_entry(tab[i], names[i]);
			check_outputs(names[i]);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/chip_mmc1.sv
`timescale 1ns/1ps
`default_nettype none

module chip_mmc1 (
	input wire logic cpu_m2,
	input wire logic rst,
	input wire logic [14:13] cpu_addr,
	input wire logic cpu_d7,
	input wire logic cpu_d0,
	input wire logic cpu_ce_n,
	input wire logic cpu_rw,
	input wire logic [12:10] ppu_addr,
	output logic wram_ce,
	output logic prg_ce_n,
	output logic ciram_a10,
	output mmc1_pkg::prg_bank_t prg_addr,
	output mmc1_pkg::chr_bank_t chr_addr,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [7:0] paddr,
	input wire logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic cpu_we;
	logic commit;
	logic loader_rst;
	mmc1_pkg::reg_sel_t commit_sel;
	mmc1_pkg::reg_word_t commit_val;
	mmc1_pkg::reg_word_t shift_q;
	logic [mmc1_pkg::CNT_W-1:0] count_q;
	logic [5:0] sst_we;
	mmc1_pkg::reg_word_t sst_wdata;
	mmc1_pkg::ctrl_fields_t ctrl;
	mmc1_pkg::chr_bank_t chr0;
	mmc1_pkg::chr_bank_t chr1;
	mmc1_pkg::prg_fields_t prg;

	// Save-state writes win over the CPU.
	assign cpu_we = !cpu_ce_n && !cpu_rw && !(psel && penable && pwrite);

	mmc1_serial_loader u_loader (
		.cpu_m2(cpu_m2),
		.rst(rst),
		.cpu_we(cpu_we),
		.cpu_rw(cpu_rw),
		.cpu_d7(cpu_d7),
		.cpu_d0(cpu_d0),
		.cpu_sel(mmc1_pkg::reg_sel_t'(cpu_addr)),
		.sst_we(sst_we[5:4]),
		.sst_wdata(sst_wdata),
		.commit(commit),
		.commit_sel(commit_sel),
		.commit_val(commit_val),
		.loader_rst(loader_rst),
		.shift_q(shift_q),
		.count_q(count_q)
	);

	mmc1_bank_regs u_regs (
		.cpu_m2(cpu_m2),
		.rst(rst),
		.commit(commit),
		.commit_sel(commit_sel),
		.commit_val(commit_val),
		.loader_rst(loader_rst),
		.sst_we(sst_we[3:0]),
		.sst_wdata(sst_wdata),
		.ctrl(ctrl),
		.chr0(chr0),
		.chr1(chr1),
		.prg(prg)
	);

	mmc1_addr_map u_map (
		.cpu_addr(cpu_addr),
		.cpu_ce_n(cpu_ce_n),
		.cpu_rw(cpu_rw),
		.ppu_addr(ppu_addr),
		.ctrl(ctrl),
		.chr0(chr0),
		.chr1(chr1),
		.prg(prg),
		.wram_ce(wram_ce),
		.prg_ce_n(prg_ce_n),
		.ciram_a10(ciram_a10),
		.prg_addr(prg_addr),
		.chr_addr(chr_addr)
	);

	mmc1_state_apb u_apb (
		.cpu_m2(cpu_m2),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.sst_we(sst_we),
		.sst_wdata(sst_wdata),
		.ctrl_raw(ctrl),
		.chr0_raw(chr0),
		.chr1_raw(chr1),
		.prg_raw(prg),
		.shift_q(shift_q),
		.count_q(count_q)
	);

endmodule

`default_nettype wire

// File: source/mmc1_addr_map.sv
`timescale 1ns/1ps
`default_nettype none

module mmc1_addr_map (
	input wire logic [14:13] cpu_addr,
	input wire logic cpu_ce_n,
	input wire logic cpu_rw,
	input wire logic [12:10] ppu_addr,
	input mmc1_pkg::ctrl_fields_t ctrl,
	input mmc1_pkg::chr_bank_t chr0,
	input mmc1_pkg::chr_bank_t chr1,
	input mmc1_pkg::prg_fields_t prg,
	output logic wram_ce,
	output logic prg_ce_n,
	output logic ciram_a10,
	output mmc1_pkg::prg_bank_t prg_addr,
	output mmc1_pkg::chr_bank_t chr_addr
);

	// Work RAM lives at $6000-$7FFF while ROM is deselected.
	assign wram_ce = cpu_ce_n && (cpu_addr == 2'b11) && !prg.wram_dis;
	assign prg_ce_n = !(!cpu_ce_n && cpu_rw);

	always_comb
	begin
		if (!ctrl.mirror[1])
			ciram_a10 = ctrl.mirror[0]; // One screen.
		else if (!ctrl.mirror[0])
			ciram_a10 = ppu_addr[10]; // Vertical.
		else
			ciram_a10 = ppu_addr[11]; // Horizontal.
	end

	always_comb
	begin
		case (ctrl.prg_mode)
			2'd2:
				prg_addr = cpu_addr[14] ? prg.bank : 4'h0;
			2'd3:
				prg_addr = cpu_addr[14] ? 4'hf : prg.bank;
			default:
				prg_addr = {prg.bank[3:1], cpu_addr[14]}; // 32K window.
		endcase
	end

	always_comb
	begin
		if (!ctrl.chr_mode)
			chr_addr = {chr0[4:1], ppu_addr[12]};
		else if (!ppu_addr[12])
			chr_addr = chr0;
		else
			chr_addr = chr1;
	end

endmodule

`default_nettype wire

// File: source/mmc1_bank_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mmc1_bank_regs (
	input wire logic cpu_m2,
	input wire logic rst,
	input wire logic commit,
	input mmc1_pkg::reg_sel_t commit_sel,
	input mmc1_pkg::reg_word_t commit_val,
	input wire logic loader_rst,
	input wire logic [3:0] sst_we,
	input mmc1_pkg::reg_word_t sst_wdata,
	output mmc1_pkg::ctrl_fields_t ctrl,
	output mmc1_pkg::chr_bank_t chr0,
	output mmc1_pkg::chr_bank_t chr1,
	output mmc1_pkg::prg_fields_t prg
);

	mmc1_pkg::reg_word_u ctrl_r;
	mmc1_pkg::reg_word_u chr0_r;
	mmc1_pkg::reg_word_u chr1_r;
	mmc1_pkg::reg_word_u prg_r;

	always_ff @(posedge cpu_m2)
	begin
		if (rst)
		begin
			ctrl_r.raw <= mmc1_pkg::RESET_CTRL;
			chr0_r.raw <= '0;
			chr1_r.raw <= '0;
			prg_r.raw <= '0; // Work RAM enabled.
		end
		else
		begin
			if (sst_we[0])
				ctrl_r.raw <= sst_wdata;
			else if (commit && commit_sel == mmc1_pkg::CTRL)
				ctrl_r.raw <= commit_val;
			else if (loader_rst)
				ctrl_r.ctrl.prg_mode <= 2'b11; // Fix last bank.

			if (sst_we[1])
				chr0_r.raw <= sst_wdata;
			else if (commit && commit_sel == mmc1_pkg::CHR0)
				chr0_r.raw <= commit_val;

			if (sst_we[2])
				chr1_r.raw <= sst_wdata;
			else if (commit && commit_sel == mmc1_pkg::CHR1)
				chr1_r.raw <= commit_val;

			if (sst_we[3])
				prg_r.raw <= sst_wdata;
			else if (commit && commit_sel == mmc1_pkg::PRG)
				prg_r.raw <= commit_val;
		end
	end

	assign ctrl = ctrl_r.ctrl;
	assign chr0 = chr0_r.raw;
	assign chr1 = chr1_r.raw;
	assign prg = prg_r.prg;

	a_loader_rst_mode: assert property (@(posedge cpu_m2) disable iff (rst)
		loader_rst |=> (ctrl.prg_mode == 2'b11));

endmodule

`default_nettype wire

// File: source/mmc1_pkg.sv
`default_nettype none

package mmc1_pkg;

	localparam int REG_W = 5;
	localparam int CNT_W = 3;
	localparam logic [CNT_W-1:0] COMMIT_COUNT = 3'd4;

	localparam logic [7:0] SST_CTRL = 8'd0;
	localparam logic [7:0] SST_CHR0 = 8'd1;
	localparam logic [7:0] SST_CHR1 = 8'd2;
	localparam logic [7:0] SST_PRG = 8'd3;
	localparam logic [7:0] SST_SHIFT = 8'd4;
	localparam logic [7:0] SST_COUNT = 8'd5;
	localparam logic [7:0] SST_LAST = 8'd5;

	localparam logic [REG_W-1:0] RESET_CTRL = 5'b11111;

	// Target follows cpu_addr[14:13].
	typedef enum logic [1:0] {CTRL, CHR0, CHR1, PRG} reg_sel_t;

	typedef logic [REG_W-1:0] reg_word_t;
	typedef logic [3:0] prg_bank_t;
	typedef logic [4:0] chr_bank_t;

	typedef struct packed {
		logic chr_mode;
		logic [1:0] prg_mode;
		logic [1:0] mirror;
	} ctrl_fields_t;

	typedef struct packed {
		logic wram_dis; // Active high disables work RAM.
		prg_bank_t bank;
	} prg_fields_t;

	typedef union packed {
		reg_word_t raw;
		ctrl_fields_t ctrl;
		prg_fields_t prg;
	} reg_word_u;

endpackage

`default_nettype wire

// File: source/mmc1_serial_loader.sv
`timescale 1ns/1ps
`default_nettype none

module mmc1_serial_loader (
	input wire logic cpu_m2,
	input wire logic rst,
	input wire logic cpu_we,
	input wire logic cpu_rw,
	input wire logic cpu_d7,
	input wire logic cpu_d0,
	input mmc1_pkg::reg_sel_t cpu_sel,
	input wire logic [5:4] sst_we,
	input mmc1_pkg::reg_word_t sst_wdata,
	output logic commit,
	output mmc1_pkg::reg_sel_t commit_sel,
	output mmc1_pkg::reg_word_t commit_val,
	output logic loader_rst,
	output mmc1_pkg::reg_word_t shift_q,
	output logic [mmc1_pkg::CNT_W-1:0] count_q
);

	mmc1_pkg::reg_word_t shift_next;
	logic rw_q; // High when the last seen cycle was a read.
	logic counted;

	// Bits enter at the top and walk down to bit 0.
	assign shift_next = {cpu_d0, shift_q[mmc1_pkg::REG_W-1:1]};

	assign counted = cpu_we && rw_q && !cpu_d7;
	assign loader_rst = cpu_we && cpu_d7;

	assign commit = counted && (count_q == mmc1_pkg::COMMIT_COUNT);
	assign commit_sel = cpu_sel;
	assign commit_val = shift_next;

	// Filters the second write of a read-modify-write pair.
	always_ff @(posedge cpu_m2)
	begin
		if (rst)
			rw_q <= 1'b1;
		else if (cpu_we || cpu_rw)
			rw_q <= cpu_rw; // Other write cycles leave history alone.
	end

	always_ff @(posedge cpu_m2)
	begin
		if (rst)
		begin
			shift_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (sst_we[4])
				shift_q <= sst_wdata;
			else if (counted)
				shift_q <= shift_next;

			if (sst_we[5])
				count_q <= sst_wdata[mmc1_pkg::CNT_W-1:0];
			else if (loader_rst)
				count_q <= '0;
			else if (counted)
			begin
				if (count_q == mmc1_pkg::COMMIT_COUNT)
					count_q <= '0; // Wrap after the commit.
				else
					count_q <= count_q + 1'b1;
			end
		end
	end

	a_commit_wrap: assert property (@(posedge cpu_m2) disable iff (rst)
		(commit && !sst_we[5]) |=> (count_q == '0));

endmodule

`default_nettype wire

// File: source/mmc1_state_apb.sv
`timescale 1ns/1ps
`default_nettype none

module mmc1_state_apb (
	input wire logic cpu_m2,
	input wire logic rst,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [7:0] paddr,
	input wire logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [5:0] sst_we,
	output mmc1_pkg::reg_word_t sst_wdata,
	input mmc1_pkg::reg_word_t ctrl_raw,
	input mmc1_pkg::reg_word_t chr0_raw,
	input mmc1_pkg::reg_word_t chr1_raw,
	input mmc1_pkg::reg_word_t prg_raw,
	input mmc1_pkg::reg_word_t shift_q,
	input wire logic [mmc1_pkg::CNT_W-1:0] count_q
);

	logic addr_ok;
	logic wr_access;

	assign addr_ok = (paddr <= mmc1_pkg::SST_LAST);
	assign wr_access = psel && penable && pwrite && addr_ok;

	always_comb
	begin
		sst_we = '0;
		if (wr_access)
			sst_we[paddr[2:0]] = 1'b1; // One strobe per state word.
	end

	assign sst_wdata = pwdata[mmc1_pkg::REG_W-1:0];

	always_comb
	begin
		case (paddr)
			mmc1_pkg::SST_CTRL: prdata = {3'b000, ctrl_raw};
			mmc1_pkg::SST_CHR0: prdata = {3'b000, chr0_raw};
			mmc1_pkg::SST_CHR1: prdata = {3'b000, chr1_raw};
			mmc1_pkg::SST_PRG: prdata = {3'b000, prg_raw};
			mmc1_pkg::SST_SHIFT: prdata = {3'b000, shift_q};
			mmc1_pkg::SST_COUNT: prdata = {5'b00000, count_q};
			default: prdata = 8'hff;
		endcase
	end

	// Set during setup so the access phase completes at once.
	always_ff @(posedge cpu_m2)
	begin
		if (rst)
		begin
			pready <= 1'b0;
			pslverr <= 1'b0;
		end
		else
		begin
			pready <= psel && !penable;
			pslverr <= psel && !penable && !addr_ok;
		end
	end

	a_penable_psel: assert property (@(posedge cpu_m2) disable iff (rst)
		penable |-> psel);

endmodule

`default_nettype wire
